/* dv/status_checker.sv */
`timescale 1ns/100ps

module status_checker #(
    parameter logic [31:0] BASE_ADDR       = 32'h3000_0000,
    parameter logic [47:0] DEFAULT_MAC     = 48'h0,
    parameter logic [31:0] DEFAULT_IP      = 32'h0,
    parameter logic [31:0] DEFAULT_HOST_IP = 32'h0
) (
    input  logic                          clk,
    input  logic                          STATUS_SLAVE_RSTN_SYNC,
    input  logic [status_pkg::ID_W-1:0]   awid, bid, arid, rid,
    input  logic [status_pkg::ADDR_W-1:0] awaddr, araddr,
    input  logic [status_pkg::DATA_W-1:0] wdata, rdata,
    input  logic [status_pkg::STRB_W-1:0] wstrb,
    input  logic [status_pkg::LEN_W-1:0]  arlen,
    input  logic [1:0]                    awburst, arburst, bresp, rresp,
    input  logic                          awvalid, awready, wvalid, wready, bvalid, bready,
    input  logic                          arvalid, arready, rlast, rvalid, rready,
    input  logic [15:0]                   bus_master_status, bus_slave_status,
    input  logic [status_pkg::DATA_W-1:0] uid_high, uid_mid, uid_low,
    input  logic                          lab_power_status, lab_power_reset,
    input  logic [status_pkg::DATA_W-1:0] bus_reset_req, ip_addr, host_ip_addr,
    input  logic [47:0]                   mac_addr,
    output int                            error_count
);
    logic [47:0] mac_m;
    logic [31:0] ip_m, host_m, bus_pulse_m;
    logic [31:0] wr_idx_m, rd_idx_m;
    logic [3:0]  wr_id_m, rd_id_m;
    logic [1:0]  wr_burst_m, rd_burst_m;
    logic [7:0]  rd_len_m, rd_beat_m;
    logic        lab_pulse_m, wr_err_m, rd_err_m;
    int          errors = 0;
    int          since_reset;

    assign error_count = errors;

    function automatic logic [31:0] byte_mask(input logic [3:0] strb);
        logic [31:0] m;
        for (int i = 0; i < 4; i++)
            m[8*i +: 8] = {8{strb[i]}};
        return m;
    endfunction

    function automatic logic burst_ok(input logic [1:0] b);
        return b == status_pkg::BURST_FIXED || b == status_pkg::BURST_INCR;
    endfunction

    function automatic logic wr_legal(input logic [31:0] idx);
        return idx == status_pkg::IDX_BUS_RESET ||
               (idx >= status_pkg::IDX_LAB_RESET && idx <= status_pkg::IDX_LAST);
    endfunction

    function automatic logic rd_legal(input logic [31:0] idx);
        return idx <= status_pkg::IDX_LAST && idx != status_pkg::IDX_BUS_RESET &&
               idx != status_pkg::IDX_LAB_RESET;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] idx);
        logic [31:0] v;
        v = '0;
        case (idx)
            status_pkg::IDX_BUS_STATUS: v = {bus_master_status, bus_slave_status};
            status_pkg::IDX_UID_HIGH:   v = uid_high;
            status_pkg::IDX_UID_MID:    v = uid_mid;
            status_pkg::IDX_UID_LOW:    v = uid_low;
            status_pkg::IDX_LAB_STATUS: v[status_pkg::LAB_POWER_BIT] = lab_power_status;
            status_pkg::IDX_MAC_HIGH:   v[15:0] = mac_m[47:32]; // zero extended
            status_pkg::IDX_MAC_LOW:    v = mac_m[31:0];
            status_pkg::IDX_LOCAL_IP:   v = ip_m;
            status_pkg::IDX_HOST_IP:    v = host_m;
            default:                    v = status_pkg::ERR_READ_DATA;
        endcase
        return v;
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    // sampled mid cycle so a handshake seen here completes at the next rising edge
    always @(negedge clk) begin
        logic        legal;
        logic [31:0] m;
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            mac_m       = DEFAULT_MAC;
            ip_m        = DEFAULT_IP;
            host_m      = DEFAULT_HOST_IP;
            bus_pulse_m = '0;
            lab_pulse_m = 1'b0;
            since_reset = 0;
            check_value("awready", awready, 0);
            check_value("arready", arready, 0);
        end else begin
            since_reset++;
            if (since_reset == 2) begin // one rising edge after release
                check_value("awready", awready, 1);
                check_value("arready", arready, 1);
                check_value("bvalid", bvalid, 0);
                check_value("rvalid", rvalid, 0);
                check_value("wready", wready, 0);
            end
            check_value("mac_addr", mac_addr, mac_m);
            check_value("ip_addr", ip_addr, ip_m);
            check_value("host_ip_addr", host_ip_addr, host_m);
            check_value("bus_reset_req", bus_reset_req, bus_pulse_m);
            check_value("lab_power_reset", lab_power_reset, lab_pulse_m);
            bus_pulse_m = '0; // pulses last one cycle
            lab_pulse_m = 1'b0;
            if (arvalid && arready) begin
                rd_id_m    = arid;
                rd_idx_m   = araddr - BASE_ADDR;
                rd_burst_m = arburst;
                rd_len_m   = arlen;
                rd_beat_m  = '0;
                rd_err_m   = 1'b0;
            end
            if (rvalid && rready) begin // before any write of this cycle lands
                legal = burst_ok(rd_burst_m) && rd_legal(rd_idx_m);
                if (!legal)
                    rd_err_m = 1'b1;
                check_value("rid", rid, rd_id_m);
                check_value("rdata", rdata,
                            legal ? expected_read(rd_idx_m) : status_pkg::ERR_READ_DATA);
                check_value("rresp", rresp,
                            rd_err_m ? status_pkg::RESP_SLVERR : status_pkg::RESP_OKAY);
                check_value("rlast", rlast, rd_beat_m == rd_len_m);
                rd_beat_m++;
                if (rd_burst_m == status_pkg::BURST_INCR)
                    rd_idx_m++;
            end
            if (awvalid && awready) begin
                wr_id_m    = awid;
                wr_idx_m   = awaddr - BASE_ADDR;
                wr_burst_m = awburst;
                wr_err_m   = 1'b0;
            end
            if (wvalid && wready) begin
                legal = burst_ok(wr_burst_m) && wr_legal(wr_idx_m);
                m     = byte_mask(wstrb);
                if (!legal)
                    wr_err_m = 1'b1;
                else
                    case (wr_idx_m)
                        status_pkg::IDX_BUS_RESET: bus_pulse_m = wdata & m;
                        status_pkg::IDX_LAB_RESET:
                            lab_pulse_m = wstrb[0] && wdata[status_pkg::LAB_POWER_BIT];
                        status_pkg::IDX_MAC_HIGH:
                            mac_m[47:32] = (mac_m[47:32] & ~m[15:0]) | (wdata[15:0] & m[15:0]);
                        status_pkg::IDX_MAC_LOW:   mac_m[31:0] = (mac_m[31:0] & ~m) | (wdata & m);
                        status_pkg::IDX_LOCAL_IP:  ip_m = (ip_m & ~m) | (wdata & m);
                        status_pkg::IDX_HOST_IP:   host_m = (host_m & ~m) | (wdata & m);
                        default: ;
                    endcase
                if (wr_burst_m == status_pkg::BURST_INCR)
                    wr_idx_m++;
            end
            if (bvalid && bready) begin
                check_value("bid", bid, wr_id_m);
                check_value("bresp", bresp,
                            wr_err_m ? status_pkg::RESP_SLVERR : status_pkg::RESP_OKAY);
            end
        end
    end

endmodule

/* dv/status_tb.sv */
`timescale 1ns/100ps

module status_tb;
    localparam logic [31:0] BASE_ADDR       = 32'h3000_0000;
    localparam logic [47:0] DEFAULT_MAC     = 48'h02_00_5E_10_20_30;
    localparam logic [31:0] DEFAULT_IP      = 32'hC0A8_0102;
    localparam logic [31:0] DEFAULT_HOST_IP = 32'hC0A8_0101;
    localparam int          TIMEOUT         = 200; // cycles per handshake
    localparam int          N_BURSTS        = 400;

    logic                          clk, STATUS_SLAVE_RSTN_SYNC;
    logic [status_pkg::ID_W-1:0]   awid, bid, arid, rid;
    logic [status_pkg::ADDR_W-1:0] awaddr, araddr;
    logic [status_pkg::DATA_W-1:0] wdata, rdata;
    logic [status_pkg::STRB_W-1:0] wstrb;
    logic [status_pkg::LEN_W-1:0]  awlen, arlen;
    logic [1:0]                    awburst, arburst, bresp, rresp;
    logic                          awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic                          arvalid, arready, rlast, rvalid, rready;
    logic [15:0]                   bus_master_status, bus_slave_status;
    logic [status_pkg::DATA_W-1:0] uid_high, uid_mid, uid_low;
    logic [status_pkg::DATA_W-1:0] bus_reset_req, ip_addr, host_ip_addr;
    logic                          lab_power_status, lab_power_reset;
    logic [47:0]                   mac_addr;
    logic [31:0]                   lfsr;
    int                            timeouts, check_errors;

    always #4 clk = ~clk;

    status_axi_top #(
        .BASE_ADDR       (BASE_ADDR),
        .DEFAULT_MAC     (DEFAULT_MAC),
        .DEFAULT_IP      (DEFAULT_IP),
        .DEFAULT_HOST_IP (DEFAULT_HOST_IP)
    ) status_axi_top_i (.*);

    status_checker #(
        .BASE_ADDR       (BASE_ADDR),
        .DEFAULT_MAC     (DEFAULT_MAC),
        .DEFAULT_IP      (DEFAULT_IP),
        .DEFAULT_HOST_IP (DEFAULT_HOST_IP)
    ) status_checker_i (.*, .error_count(check_errors));

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]}; // one step per bit
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout waiting for %s at %0t ns", what, $time);
        timeouts++;
    endtask

    task automatic refresh_status();
        logic [31:0] v;
        draw(32, v);
        {bus_master_status, bus_slave_status} = v;
        draw(32, v);
        uid_high = v;
        draw(32, v);
        uid_mid = v;
        draw(32, v);
        uid_low = v;
        draw(1, v);
        lab_power_status = v[0];
    endtask

    task automatic write_burst(input logic [3:0] id, input logic [31:0] idx,
                               input logic [1:0] burst, input int len);
        logic [31:0] v;
        int          n;
        logic        done;
        awid    = id;
        awaddr  = BASE_ADDR + idx;
        awlen   = 8'(len); // informational, wlast ends the burst
        awburst = burst;
        awvalid = 1'b1;
        n = 0;
        while (!awready && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!awready)
            note_timeout("awready");
        tick();
        awvalid = 1'b0;
        for (int b = 0; b <= len; b++) begin
            draw(32, v);
            wdata = v;
            draw(4, v);
            wstrb  = v[3:0];
            wlast  = (b == len);
            wvalid = 1'b1;
            n = 0;
            while (!wready && n < TIMEOUT) begin
                tick();
                n++;
            end
            if (!wready)
                note_timeout("wready");
            tick();
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        n    = 0;
        done = 1'b0;
        while (!done && n < TIMEOUT) begin
            draw(1, v);
            bready = v[0]; // random stall
            done   = bvalid && bready;
            tick();
            n++;
        end
        bready = 1'b0;
        if (!done)
            note_timeout("write response");
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] idx,
                              input logic [1:0] burst, input int len);
        logic [31:0] v;
        int          n;
        int          beats;
        arid    = id;
        araddr  = BASE_ADDR + idx;
        arlen   = 8'(len);
        arburst = burst;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!arready)
            note_timeout("arready");
        tick();
        arvalid = 1'b0;
        n     = 0;
        beats = 0;
        while (beats <= len && n < TIMEOUT) begin
            draw(1, v);
            rready = v[0];
            if (rvalid && rready)
                beats++;
            tick();
            n++;
        end
        rready = 1'b0;
        if (beats <= len)
            note_timeout("read data beats");
    endtask

    initial begin
        logic [31:0] v;
        logic [3:0]  id;
        logic [31:0] idx;
        logic [1:0]  burst;
        int          len;
        clk = 1'b0;
        STATUS_SLAVE_RSTN_SYNC = 1'b0;
        {awid, awaddr, awlen, awburst, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arburst, arvalid, rready} = '0;
        lfsr     = 32'h3b4e;
        timeouts = 0;
        refresh_status();
        repeat (3) @(posedge clk);
        #1;
        STATUS_SLAVE_RSTN_SYNC = 1'b1;
        for (int t = 0; t < N_BURSTS; t++) begin
            draw(4, v);
            id = v[3:0];
            draw(4, v);
            idx = v; // 0xb..0xf unmapped
            draw(3, v);
            burst = (v[2:1] == 2'b11) ? {1'b1, v[0]} : {1'b0, v[0]}; // a quarter illegal
            draw(2, v);
            len = int'(v);
            draw(1, v);
            if (v[0])
                write_burst(id, idx, burst, len);
            else
                read_burst(id, idx, burst, len);
            draw(3, v);
            if (v[2:0] == 3'd0)
                refresh_status();
        end
        repeat (4) tick();
        $display("checker errors: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the status slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module status_tb \
        -f status_axi.f -o status_sim; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/status_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Finished with no errors"; then
    exit 0
fi
exit 1

/* source/status_axi_top.sv */
`timescale 1ns/100ps

module status_axi_top #(
    parameter logic [31:0] BASE_ADDR       = 32'h3000_0000,
    parameter logic [47:0] DEFAULT_MAC     = 48'h12_34_56_78_AB_CD,
    parameter logic [31:0] DEFAULT_IP      = 32'hA9FE_6D05,
    parameter logic [31:0] DEFAULT_HOST_IP = 32'hA9FE_6D01
) (
    input  logic                            clk,
    input  logic                            STATUS_SLAVE_RSTN_SYNC,
    input  logic [status_pkg::ID_W-1:0]     awid,
    input  logic [status_pkg::ADDR_W-1:0]   awaddr,
    input  logic [status_pkg::LEN_W-1:0]    awlen, // burst end comes from wlast
    input  logic [1:0]                      awburst,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [status_pkg::DATA_W-1:0]   wdata,
    input  logic [status_pkg::STRB_W-1:0]   wstrb,
    input  logic                            wlast,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [status_pkg::ID_W-1:0]     bid,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [status_pkg::ID_W-1:0]     arid,
    input  logic [status_pkg::ADDR_W-1:0]   araddr,
    input  logic [status_pkg::LEN_W-1:0]    arlen,
    input  logic [1:0]                      arburst,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [status_pkg::ID_W-1:0]     rid,
    output logic [status_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                      rresp,
    output logic                            rlast,
    output logic                            rvalid,
    input  logic                            rready,
    input  logic [15:0]                     bus_master_status,
    input  logic [15:0]                     bus_slave_status,
    input  logic [status_pkg::DATA_W-1:0]   uid_high,
    input  logic [status_pkg::DATA_W-1:0]   uid_mid,
    input  logic [status_pkg::DATA_W-1:0]   uid_low,
    input  logic                            lab_power_status,
    output logic [status_pkg::DATA_W-1:0]   bus_reset_req,
    output logic                            lab_power_reset,
    output logic [47:0]                     mac_addr,
    output logic [status_pkg::DATA_W-1:0]   ip_addr,
    output logic [status_pkg::DATA_W-1:0]   host_ip_addr
);
    logic [status_pkg::ADDR_W-1:0] reg_wr_idx, reg_rd_idx;
    logic [status_pkg::DATA_W-1:0] reg_wr_data, reg_rd_data;
    logic [status_pkg::STRB_W-1:0] reg_wr_strb;
    logic                          reg_wr_en, wr_idx_bad, rd_idx_bad;

    // write side, one burst in flight
    status_wr_channel #(
        .BASE_ADDR (BASE_ADDR)
    ) status_wr_channel_i (
        .clk, .STATUS_SLAVE_RSTN_SYNC,
        .awid, .awaddr, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready,
        .wr_idx_bad, .reg_wr_idx, .reg_wr_en, .reg_wr_data, .reg_wr_strb
    );

    // read side runs independently of writes
    status_rd_channel #(
        .BASE_ADDR (BASE_ADDR)
    ) status_rd_channel_i (
        .clk, .STATUS_SLAVE_RSTN_SYNC,
        .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .reg_rd_idx, .rd_idx_bad, .reg_rd_data
    );

    status_reg_file #(
        .DEFAULT_MAC     (DEFAULT_MAC),
        .DEFAULT_IP      (DEFAULT_IP),
        .DEFAULT_HOST_IP (DEFAULT_HOST_IP)
    ) status_reg_file_i (
        .clk, .STATUS_SLAVE_RSTN_SYNC,
        .reg_wr_idx, .reg_wr_en, .reg_wr_data, .reg_wr_strb, .wr_idx_bad,
        .reg_rd_idx, .reg_rd_data, .rd_idx_bad,
        .bus_master_status, .bus_slave_status,
        .uid_high, .uid_mid, .uid_low, .lab_power_status,
        .bus_reset_req, .lab_power_reset,
        .mac_addr, .ip_addr, .host_ip_addr
    );

endmodule

/* source/status_pkg.sv */
package status_pkg;

    // AXI bus widths
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;

    // burst type codes, 2 and 3 are rejected
    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;

    // response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // word indices, address minus base
    localparam logic [ADDR_W-1:0] IDX_BUS_STATUS = 32'h0000_0000; // read only
    localparam logic [ADDR_W-1:0] IDX_BUS_RESET  = 32'h0000_0001; // write only, pulse
    localparam logic [ADDR_W-1:0] IDX_UID_HIGH   = 32'h0000_0002;
    localparam logic [ADDR_W-1:0] IDX_UID_MID    = 32'h0000_0003;
    localparam logic [ADDR_W-1:0] IDX_UID_LOW    = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] IDX_LAB_STATUS = 32'h0000_0005; // read only
    localparam logic [ADDR_W-1:0] IDX_LAB_RESET  = 32'h0000_0006; // write only, pulse
    localparam logic [ADDR_W-1:0] IDX_MAC_HIGH   = 32'h0000_0007; // upper 16 mac bits
    localparam logic [ADDR_W-1:0] IDX_MAC_LOW    = 32'h0000_0008;
    localparam logic [ADDR_W-1:0] IDX_LOCAL_IP   = 32'h0000_0009;
    localparam logic [ADDR_W-1:0] IDX_HOST_IP    = 32'h0000_000A;
    localparam logic [ADDR_W-1:0] IDX_LAST       = IDX_HOST_IP; // anything above is an error

    // power flag position at indices 5 and 6
    localparam int LAB_POWER_BIT = 7;

    // returned on a read of an unmapped index
    localparam logic [DATA_W-1:0] ERR_READ_DATA = 32'hFFFF_FFFF;

endpackage

/* source/status_rd_channel.sv */
`timescale 1ns/100ps

module status_rd_channel #(
    parameter logic [31:0] BASE_ADDR = 32'h3000_0000
) (
    input  logic                            clk,
    input  logic                            STATUS_SLAVE_RSTN_SYNC,
    input  logic [status_pkg::ID_W-1:0]     arid,
    input  logic [status_pkg::ADDR_W-1:0]   araddr,
    input  logic [status_pkg::LEN_W-1:0]    arlen,
    input  logic [1:0]                      arburst,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [status_pkg::ID_W-1:0]     rid,
    output logic [status_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                      rresp,
    output logic                            rlast,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [status_pkg::ADDR_W-1:0]   reg_rd_idx,
    input  logic                            rd_idx_bad,
    input  logic [status_pkg::DATA_W-1:0]   reg_rd_data
);
    typedef enum logic {
        ST_IDLE,
        ST_DATA
    } rd_state_t;

    rd_state_t                     state, state_nxt;
    logic [status_pkg::ID_W-1:0]   rd_id;
    logic [status_pkg::LEN_W-1:0]  rd_len;
    logic [status_pkg::LEN_W-1:0]  rd_cnt; // beats already taken
    logic [1:0]                    rd_burst;
    logic [status_pkg::ADDR_W-1:0] rd_idx;
    logic                          err_sticky;
    logic                          ar_hs, r_hs;
    logic                          burst_bad, beat_err;

    assign ar_hs     = arvalid && arready;
    assign r_hs      = rvalid && rready;
    assign burst_bad = (rd_burst != status_pkg::BURST_FIXED) &&
                       (rd_burst != status_pkg::BURST_INCR);
    assign beat_err  = burst_bad || rd_idx_bad;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (ar_hs) state_nxt = ST_DATA;
            ST_DATA: if (r_hs && rlast) state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state      <= ST_IDLE;
            arready    <= 1'b0;
            err_sticky <= 1'b0;
        end else begin
            state   <= state_nxt;
            arready <= (state_nxt == ST_IDLE);
            if (ar_hs)
                err_sticky <= 1'b0;
            else if (r_hs && beat_err)
                err_sticky <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_id    <= arid;
            rd_len   <= arlen;
            rd_burst <= arburst;
            rd_idx   <= araddr - BASE_ADDR;
            rd_cnt   <= '0;
        end else if (r_hs) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_burst == status_pkg::BURST_INCR)
                rd_idx <= rd_idx + 1'b1;
        end
    end

    assign rvalid     = (state == ST_DATA);
    assign rlast      = rvalid && (rd_cnt == rd_len);
    assign rid        = rd_id;
    assign reg_rd_idx = rd_idx;
    assign rdata      = burst_bad ? status_pkg::ERR_READ_DATA : reg_rd_data;
    assign rresp      = (err_sticky || beat_err) ? status_pkg::RESP_SLVERR
                                                 : status_pkg::RESP_OKAY;

    // beat held steady while the master stalls
    assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid && !rready |=> $stable(rdata) && $stable(rlast) && $stable(rresp));

    // no new address taken while a burst is out
    assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid |-> !arready);

endmodule

/* source/status_reg_file.sv */
`timescale 1ns/100ps

module status_reg_file #(
    parameter logic [47:0] DEFAULT_MAC     = 48'h12_34_56_78_AB_CD,
    parameter logic [31:0] DEFAULT_IP      = 32'hA9FE_6D05,
    parameter logic [31:0] DEFAULT_HOST_IP = 32'hA9FE_6D01
) (
    input  logic                            clk,
    input  logic                            STATUS_SLAVE_RSTN_SYNC,
    input  logic [status_pkg::ADDR_W-1:0]   reg_wr_idx,
    input  logic                            reg_wr_en,
    input  logic [status_pkg::DATA_W-1:0]   reg_wr_data,
    input  logic [status_pkg::STRB_W-1:0]   reg_wr_strb,
    output logic                            wr_idx_bad,
    input  logic [status_pkg::ADDR_W-1:0]   reg_rd_idx,
    output logic [status_pkg::DATA_W-1:0]   reg_rd_data,
    output logic                            rd_idx_bad,
    input  logic [15:0]                     bus_master_status,
    input  logic [15:0]                     bus_slave_status,
    input  logic [status_pkg::DATA_W-1:0]   uid_high,
    input  logic [status_pkg::DATA_W-1:0]   uid_mid,
    input  logic [status_pkg::DATA_W-1:0]   uid_low,
    input  logic                            lab_power_status,
    output logic [status_pkg::DATA_W-1:0]   bus_reset_req,
    output logic                            lab_power_reset,
    output logic [47:0]                     mac_addr,
    output logic [status_pkg::DATA_W-1:0]   ip_addr,
    output logic [status_pkg::DATA_W-1:0]   host_ip_addr
);
    logic [status_pkg::DATA_W-1:0] wr_mask; // strobes widened to bits

    // keep unstrobed bytes of the old word
    function automatic logic [status_pkg::DATA_W-1:0] strb_merge(
        input logic [status_pkg::DATA_W-1:0] old_word,
        input logic [status_pkg::DATA_W-1:0] wr_word,
        input logic [status_pkg::DATA_W-1:0] mask
    );
        return (old_word & ~mask) | (wr_word & mask);
    endfunction

    always_comb begin
        for (int i = 0; i < status_pkg::STRB_W; i++)
            wr_mask[8*i +: 8] = {8{reg_wr_strb[i]}};
    end

    // writable: bus reset pulse, lab reset pulse, mac and ip words
    assign wr_idx_bad = !((reg_wr_idx == status_pkg::IDX_BUS_RESET) ||
                          (reg_wr_idx >= status_pkg::IDX_LAB_RESET &&
                           reg_wr_idx <= status_pkg::IDX_LAST));

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            mac_addr        <= DEFAULT_MAC;
            ip_addr         <= DEFAULT_IP;
            host_ip_addr    <= DEFAULT_HOST_IP;
            bus_reset_req   <= '0;
            lab_power_reset <= 1'b0;
        end else begin
            bus_reset_req   <= '0; // pulses clear by themselves
            lab_power_reset <= 1'b0;
            if (reg_wr_en) begin
                case (reg_wr_idx)
                    status_pkg::IDX_BUS_RESET:
                        bus_reset_req <= reg_wr_data & wr_mask;
                    status_pkg::IDX_LAB_RESET:
                        lab_power_reset <= reg_wr_strb[0] &&
                                           reg_wr_data[status_pkg::LAB_POWER_BIT];
                    status_pkg::IDX_MAC_HIGH: // only two bytes exist here
                        mac_addr[47:32] <= (mac_addr[47:32] & ~wr_mask[15:0]) |
                                           (reg_wr_data[15:0] & wr_mask[15:0]);
                    status_pkg::IDX_MAC_LOW:
                        mac_addr[31:0] <= strb_merge(mac_addr[31:0], reg_wr_data, wr_mask);
                    status_pkg::IDX_LOCAL_IP:
                        ip_addr <= strb_merge(ip_addr, reg_wr_data, wr_mask);
                    status_pkg::IDX_HOST_IP:
                        host_ip_addr <= strb_merge(host_ip_addr, reg_wr_data, wr_mask);
                    default: ;
                endcase
            end
        end
    end

    // read mux, write only and unmapped words give all ones
    always_comb begin
        rd_idx_bad  = 1'b0;
        reg_rd_data = '0;
        case (reg_rd_idx)
            status_pkg::IDX_BUS_STATUS: reg_rd_data = {bus_master_status, bus_slave_status};
            status_pkg::IDX_UID_HIGH:   reg_rd_data = uid_high;
            status_pkg::IDX_UID_MID:    reg_rd_data = uid_mid;
            status_pkg::IDX_UID_LOW:    reg_rd_data = uid_low;
            status_pkg::IDX_LAB_STATUS: reg_rd_data[status_pkg::LAB_POWER_BIT] = lab_power_status;
            status_pkg::IDX_MAC_HIGH:   reg_rd_data = {16'b0, mac_addr[47:32]};
            status_pkg::IDX_MAC_LOW:    reg_rd_data = mac_addr[31:0];
            status_pkg::IDX_LOCAL_IP:   reg_rd_data = ip_addr;
            status_pkg::IDX_HOST_IP:    reg_rd_data = host_ip_addr;
            default: begin
                rd_idx_bad  = 1'b1;
                reg_rd_data = status_pkg::ERR_READ_DATA;
            end
        endcase
    end

    // the write channel must drop the enable on an illegal index
    assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        !(reg_wr_en && wr_idx_bad));

endmodule

/* source/status_wr_channel.sv */
`timescale 1ns/100ps

module status_wr_channel #(
    parameter logic [31:0] BASE_ADDR = 32'h3000_0000
) (
    input  logic                            clk,
    input  logic                            STATUS_SLAVE_RSTN_SYNC,
    input  logic [status_pkg::ID_W-1:0]     awid,
    input  logic [status_pkg::ADDR_W-1:0]   awaddr,
    input  logic [1:0]                      awburst,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [status_pkg::DATA_W-1:0]   wdata,
    input  logic [status_pkg::STRB_W-1:0]   wstrb,
    input  logic                            wlast,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [status_pkg::ID_W-1:0]     bid,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic                            wr_idx_bad,
    output logic [status_pkg::ADDR_W-1:0]   reg_wr_idx,
    output logic                            reg_wr_en,
    output logic [status_pkg::DATA_W-1:0]   reg_wr_data,
    output logic [status_pkg::STRB_W-1:0]   reg_wr_strb
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_RESP
    } wr_state_t;

    wr_state_t                     state, state_nxt;
    logic [status_pkg::ID_W-1:0]   wr_id;
    logic [1:0]                    wr_burst;
    logic [status_pkg::ADDR_W-1:0] wr_idx;
    logic                          err_sticky; // held until the next aw handshake
    logic                          aw_hs, w_hs, b_hs;
    logic                          burst_bad, beat_err;

    assign aw_hs     = awvalid && awready;
    assign w_hs      = wvalid && wready;
    assign b_hs      = bvalid && bready;
    assign burst_bad = (wr_burst != status_pkg::BURST_FIXED) &&
                       (wr_burst != status_pkg::BURST_INCR);
    assign beat_err  = burst_bad || wr_idx_bad;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (aw_hs) state_nxt = ST_DATA;
            ST_DATA: if (w_hs && wlast) state_nxt = ST_RESP; // awlen ignored
            ST_RESP: if (b_hs) state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state      <= ST_IDLE;
            awready    <= 1'b0;
            err_sticky <= 1'b0;
        end else begin
            state   <= state_nxt;
            awready <= (state_nxt == ST_IDLE); // low from aw until b handshake
            if (aw_hs)
                err_sticky <= 1'b0;
            else if (w_hs && beat_err)
                err_sticky <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_id    <= awid;
            wr_burst <= awburst;
            wr_idx   <= awaddr - BASE_ADDR; // word index
        end else if (w_hs && wr_burst == status_pkg::BURST_INCR) begin
            wr_idx <= wr_idx + 1'b1; // fixed bursts stay put
        end
    end

    assign wready      = (state == ST_DATA);
    assign bvalid      = (state == ST_RESP);
    assign bid         = wr_id;
    assign bresp       = err_sticky ? status_pkg::RESP_SLVERR : status_pkg::RESP_OKAY;
    assign reg_wr_idx  = wr_idx;
    assign reg_wr_en   = w_hs && !beat_err;
    assign reg_wr_data = wdata;
    assign reg_wr_strb = wstrb;

    // response held with the same id and code until bready
    assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp));

endmodule

/* status_axi.f */
source/status_pkg.sv
source/status_wr_channel.sv
source/status_rd_channel.sv
source/status_reg_file.sv
source/status_axi_top.sv
dv/status_checker.sv
dv/status_tb.sv
